// File: u712_defs.svh
// U712 bus slave constants
// address map, bus widths, chip RAM geometry and the ID word
`ifndef U712_DEFS_SVH
`define U712_DEFS_SVH

// 68040 bus widths
`define ADDR_W 32
`define DATA_W 32

// chip RAM window, longword organised
`define CHIP_BASE 32'h0000_0000
`define CHIP_WORDS 256
`define RAM_AW 8
`define CHIP_BYTES (`CHIP_WORDS * 4)

// register window, four longword slots
`define REG_BASE 32'h00DF_F000
`define REG_BYTES 16

// wait states between decode and acknowledge, must be at least 1
`define CHIP_WAIT 3

// value returned by the ID register
`define U712_ID 32'h0712_0600

`endif

// File: busPkg.sv
// 68040 bus types
// transfer size as coded on SIZ, decoded target and the TACK sequencer states
package busPkg;

    // SIZ[1:0] as driven by the CPU
    typedef enum logic [1:0] {
        longSize = 2'b00,
        byteSize = 2'b01,
        wordSize = 2'b10,
        lineSize = 2'b11
    } xferSize;

    // which block answers the cycle
    // targetNone means unmapped, nobody acknowledges
    typedef enum logic [1:0] {
        targetNone = 2'd0,
        targetReg  = 2'd1,
        targetRam  = 2'd2
    } targetSel;

    // termination sequence: idle, TACKn low, TACKn driven high
    typedef enum logic [1:0] {
        tackIdle    = 2'd0,
        tackAck     = 2'd1,
        tackRelease = 2'd2
    } tackState;

endpackage

// File: regPkg.sv
// register space types
// register select decode and the layout of the access counter word
package regPkg;

    // slot select from address bits 3:2
    // slot 3 is not implemented and reads zero
    typedef enum logic [1:0] {
        regId          = 2'd0,
        regScratch     = 2'd1,
        regAccessCount = 2'd2
    } regIndex;

    // live bits of the access counter
    localparam int COUNT_W = 16;

    // counter word as seen on the bus
    // upper half always reads zero
    typedef struct packed {
        logic [31-COUNT_W:0] reserved;
        logic [COUNT_W-1:0]  count;
    } accessReg;

endpackage

// File: cpuCycleIf.sv
// captured CPU cycle
// one decoded 68040 transfer, passed from the decoder to both targets
`timescale 1ns/1ps
`include "u712_defs.svh"

interface cpuCycleIf
    import busPkg::*, regPkg::*;
();
    // one-clock pulse, the fields below are stable around it
    logic                 cycleValid;
    // decoded destination
    targetSel             dest;
    regIndex              regSel;
    logic [`RAM_AW-1:0]   ramWord;
    // high for a read, same sense as RWn
    logic                 rw;
    xferSize              size;
    logic [1:0]           byteAddr;
    logic [`DATA_W-1:0]   writeData;

    modport decoder (
        output cycleValid, dest, regSel, ramWord, rw, size, byteAddr, writeData
    );

    modport target (
        input cycleValid, dest, regSel, ramWord, rw, size, byteAddr, writeData
    );

endinterface

// File: cycleDecode.sv
// 68040 cycle decoder
// samples TSn, latches the cycle attributes and picks register or chip RAM
`timescale 1ns/1ps
`include "u712_defs.svh"

module cycleDecode
    import busPkg::*, regPkg::*;
(
    input  logic                CLK40,
    input  logic                RESETn,
    input  logic                TSn,
    input  logic [`ADDR_W-1:0]  address,
    input  logic                RWn,
    input  logic [1:0]          SIZ,
    input  logic [`DATA_W-1:0]  dataIn,
    cpuCycleIf.decoder          cyc
);

    logic [`ADDR_W-1:0] ramOff;
    logic [`ADDR_W-1:0] regOff;
    logic               ramHit;
    logic               regHit;
    targetSel           hitSel;
    logic               cycleOpen;
    logic               takeStart;

    ////////////////////
    // address decode
    ////////////////////

    // offsets into each window, wraps below the base so one compare is enough
    assign ramOff = address - `CHIP_BASE;
    assign regOff = address - `REG_BASE;
    assign ramHit = ramOff < `CHIP_BYTES;
    assign regHit = regOff < `REG_BYTES;

    assign hitSel = ramHit ? targetRam : (regHit ? targetReg : targetNone);

    // TSn is only taken while no cycle is in decode
    assign takeStart = !TSn && !cycleOpen;

    ////////////////////
    // cycle control
    ////////////////////

    // edge 0 opens the cycle, edge 1 issues cycleValid
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            cycleOpen      <= 1'b0;
            cyc.cycleValid <= 1'b0;
            cyc.dest       <= targetNone;
        end else begin
            cyc.cycleValid <= 1'b0;
            if (takeStart) begin
                cycleOpen <= 1'b1;
                cyc.dest  <= hitSel;
            end else if (cycleOpen) begin
                cycleOpen      <= 1'b0;
                // unmapped cycles are simply dropped
                cyc.cycleValid <= (cyc.dest != targetNone);
            end
        end
    end

    // attributes held for the whole cycle, next TSn overwrites them
    always_ff @(posedge CLK40) begin
        if (takeStart) begin
            cyc.regSel    <= regIndex'(regOff[3:2]);
            cyc.ramWord   <= ramOff[`RAM_AW+1:2];
            cyc.rw        <= RWn;
            cyc.size      <= xferSize'(SIZ);
            cyc.byteAddr  <= address[1:0];
            cyc.writeData <= dataIn;
        end
    end

    // CPU must not start a new transfer inside the decode window
    assert property (@(posedge CLK40) disable iff (!RESETn) cycleOpen |-> TSn);

    // software only touches the register block with longword moves
    assert property (@(posedge CLK40) disable iff (!RESETn)
        (cyc.cycleValid && cyc.dest == targetReg) |-> (cyc.size == longSize));

endmodule

// File: regBlock.sv
// U712 register block
// ID, scratch and access counter, acknowledged one clock after decode
`timescale 1ns/1ps
`include "u712_defs.svh"

module regBlock
    import busPkg::*, regPkg::*;
(
    input  logic                CLK40,
    input  logic                RESETn,
    cpuCycleIf.target           cyc,
    output logic                regAck,
    output logic [`DATA_W-1:0]  regData
);

    logic               regHit;
    logic               scratchWr;
    logic [`DATA_W-1:0] scratch;
    accessReg           accessCount;

    // only cycles decoded for the register window
    assign regHit    = cyc.cycleValid && (cyc.dest == targetReg);
    assign scratchWr = regHit && !cyc.rw && (cyc.regSel == regScratch);

    ////////////////////
    // register state
    ////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            regAck      <= 1'b0;
            scratch     <= '0;
            accessCount <= '0;
        end else begin
            // ack follows cycleValid by exactly one clock
            regAck <= regHit;
            if (scratchWr) begin
                scratch <= cyc.writeData;
            end
            // every access counts, reads and writes alike
            if (regHit) begin
                accessCount.count <= accessCount.count + 1'b1;
            end
        end
    end

    ////////////////////
    // read mux
    ////////////////////

    // sampled on the same edge as the counter bump,
    // so a counter read sees the count from before this access
    always_ff @(posedge CLK40) begin
        if (regHit && cyc.rw) begin
            case (cyc.regSel)
                regId: begin
                    regData <= `U712_ID;
                end
                regScratch: begin
                    regData <= scratch;
                end
                regAccessCount: begin
                    regData <= accessCount;
                end
                default: begin
                    // unused slot
                    regData <= '0;
                end
            endcase
        end
    end

endmodule

// File: chipRamCtrl.sv
// chip RAM model
// longword array with fixed wait states and big-endian byte lane writes
`timescale 1ns/1ps
`include "u712_defs.svh"

module chipRamCtrl
    import busPkg::*;
(
    input  logic                CLK40,
    input  logic                RESETn,
    cpuCycleIf.target           cyc,
    output logic                ramAck,
    output logic [`DATA_W-1:0]  ramData
);

    localparam int WAIT_W = $clog2(`CHIP_WAIT + 1);

    logic [`DATA_W-1:0] ram [0:`CHIP_WORDS-1];
    logic               ramHit;
    logic               waitBusy;
    logic [WAIT_W-1:0]  waitCnt;
    logic               ackNext;
    logic [3:0]         laneEn;

    assign ramHit  = cyc.cycleValid && (cyc.dest == targetRam);
    // last wait state, the access happens on this edge
    assign ackNext = waitBusy && (waitCnt == '0);

    ////////////////////
    // wait states
    ////////////////////

    // loaded one short so ramAck lands CHIP_WAIT clocks after regAck would
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            waitBusy <= 1'b0;
            waitCnt  <= '0;
            ramAck   <= 1'b0;
        end else begin
            ramAck <= ackNext;
            if (ramHit) begin
                waitBusy <= 1'b1;
                waitCnt  <= WAIT_W'(`CHIP_WAIT - 1);
            end else if (ackNext) begin
                waitBusy <= 1'b0;
            end else if (waitBusy) begin
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

    ////////////////////
    // byte lanes
    ////////////////////

    // laneEn[3] is bits 31:24, the byte at offset 0
    always_comb begin
        case (cyc.size)
            byteSize: begin
                laneEn = 4'b1000 >> cyc.byteAddr;
            end
            wordSize: begin
                laneEn = cyc.byteAddr[1] ? 4'b0011 : 4'b1100;
            end
            default: begin
                laneEn = 4'b1111;
            end
        endcase
    end

    // write lanes and read the full longword on the ack edge
    always_ff @(posedge CLK40) begin
        if (ackNext) begin
            if (!cyc.rw) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (laneEn[lane]) begin
                        ram[cyc.ramWord][lane*8 +: 8] <= cyc.writeData[lane*8 +: 8];
                    end
                end
            end
            ramData <= ram[cyc.ramWord];
        end
    end

    // bursts are refused by TBIn, so a line transfer never reaches the array
    assert property (@(posedge CLK40) disable iff (!RESETn) ramHit |-> (cyc.size != lineSize));

endmodule

// File: cycleTerm.sv
// 68040 cycle termination
// drives TACKn, TBIn and TCIn low then high for one clock each, then releases
// read data is presented while TACKn is low
`timescale 1ns/1ps
`include "u712_defs.svh"

module cycleTerm
    import busPkg::*;
(
    input  logic                CLK40,
    input  logic                RESETn,
    input  logic                regAck,
    input  logic [`DATA_W-1:0]  regData,
    input  logic                ramAck,
    input  logic [`DATA_W-1:0]  ramData,
    input  logic                readCycle,
    output logic                TACKn,
    output logic                TBIn,
    output logic                TCIn,
    output logic                tackOe,
    output logic [`DATA_W-1:0]  dataOut,
    output logic                dataOe
);

    tackState state;
    logic     tackStart;

    // no bursts and no caching, so TBIn and TCIn always follow TACKn
    assign TBIn = TACKn;
    assign TCIn = TACKn;

    // start request, held until the sequencer turns its drivers on
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            tackStart <= 1'b0;
        end else if (state == tackIdle && tackStart) begin
            tackStart <= 1'b0;
        end else if (regAck || ramAck) begin
            tackStart <= 1'b1;
        end
    end

    ////////////////////
    // TACK sequencer
    ////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state  <= tackIdle;
            tackOe <= 1'b0;
            TACKn  <= 1'b1;
            dataOe <= 1'b0;
        end else begin
            case (state)
                tackIdle: begin
                    if (tackStart) begin
                        state  <= tackAck;
                        tackOe <= 1'b1;
                        TACKn  <= 1'b0;
                        dataOe <= readCycle;
                    end
                end
                tackAck: begin
                    // drive high for a clock before letting go
                    state  <= tackRelease;
                    TACKn  <= 1'b1;
                    dataOe <= 1'b0;
                end
                tackRelease: begin
                    state  <= tackIdle;
                    tackOe <= 1'b0;
                end
                default: begin
                    state <= tackIdle;
                end
            endcase
        end
    end

    // read data from whichever target answered
    always_ff @(posedge CLK40) begin
        if (regAck) begin
            dataOut <= regData;
        end else if (ramAck) begin
            dataOut <= ramData;
        end
    end

    // decode selects one target per cycle
    assert property (@(posedge CLK40) disable iff (!RESETn) !(regAck && ramAck));

    // CPU waits for the release before the next TSn, so no ack overlaps a termination
    assert property (@(posedge CLK40) disable iff (!RESETn) (regAck || ramAck) |-> !tackOe);

endmodule

// File: u712Bus.sv
// U712 68040 slave
// decoder, register block, chip RAM and cycle termination tied together
`timescale 1ns/1ps
`include "u712_defs.svh"

module u712Bus (
    input  logic                CLK40,
    input  logic                RESETn,
    input  logic                TSn,
    input  logic [`ADDR_W-1:0]  address,
    input  logic                RWn,
    input  logic [1:0]          SIZ,
    input  logic [`DATA_W-1:0]  dataIn,
    output logic                TACKn,
    output logic                TBIn,
    output logic                TCIn,
    output logic                tackOe,
    output logic [`DATA_W-1:0]  dataOut,
    output logic                dataOe
);

    // decoded cycle shared by both targets
    cpuCycleIf cycBus ();

    logic               regAck;
    logic [`DATA_W-1:0] regData;
    logic               ramAck;
    logic [`DATA_W-1:0] ramData;

    cycleDecode i_cycleDecode (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .TSn     (TSn),
        .address (address),
        .RWn     (RWn),
        .SIZ     (SIZ),
        .dataIn  (dataIn),
        .cyc     (cycBus.decoder)
    );

    regBlock i_regBlock (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .cyc     (cycBus.target),
        .regAck  (regAck),
        .regData (regData)
    );

    chipRamCtrl i_chipRamCtrl (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .cyc     (cycBus.target),
        .ramAck  (ramAck),
        .ramData (ramData)
    );

    // direction comes straight from the captured cycle
    cycleTerm i_cycleTerm (
        .CLK40     (CLK40),
        .RESETn    (RESETn),
        .regAck    (regAck),
        .regData   (regData),
        .ramAck    (ramAck),
        .ramData   (ramData),
        .readCycle (cycBus.rw),
        .TACKn     (TACKn),
        .TBIn      (TBIn),
        .TCIn      (TCIn),
        .tackOe    (tackOe),
        .dataOut   (dataOut),
        .dataOe    (dataOe)
    );

endmodule

// File: tbClock.sv
// testbench clock and reset
// CLK40 with a 4 ns period, RESETn held low for a fixed number of cycles
`timescale 1ns/1ps

module tbClock #(
    parameter int RESET_CYCLES = 8
) (
    output logic CLK40,
    output logic RESETn
);

    // 2 ns half period
    initial begin
        CLK40 = 1'b0;
        forever #2 CLK40 = ~CLK40;
    end

    // synchronous release on a rising edge
    initial begin
        RESETn = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK40);
        RESETn <= 1'b1;
    end

endmodule

// File: tbU712Bus.sv
// U712 bus testbench
// LFSR driven register and chip RAM cycles against a reference model,
// checks termination shape, timing and read data at every clock
`timescale 1ns/1ps
`include "u712_defs.svh"

module tbU712Bus
    import busPkg::*, regPkg::*;
();

    localparam int          NUM_CYCLES     = 200;
    localparam int          FILL_WORDS     = 16;
    localparam int          RESET_CYCLES   = 8;
    localparam int          TIMEOUT_CYCLES = NUM_CYCLES * 12 + RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED      = 32'he0611fff;

    // what the checker expects from one issued cycle
    typedef struct packed {
        logic        isReg;
        logic        rd;
        logic [31:0] data;
    } expItem;

    logic               CLK40;
    logic               RESETn;
    logic               TSn;
    logic [`ADDR_W-1:0] address;
    logic               RWn;
    logic [1:0]         SIZ;
    logic [`DATA_W-1:0] dataIn;
    logic               TACKn;
    logic               TBIn;
    logic               TCIn;
    logic               tackOe;
    logic [`DATA_W-1:0] dataOut;
    logic               dataOe;

    // reference state
    logic [31:0] refRam [0:`CHIP_WORDS-1];
    logic [31:0] refScratch;
    int          refCount;
    logic [31:0] lfsrState;

    // checker state
    expItem      expQ[$];
    expItem      cur;
    logic        active = 1'b0;
    int          edgeNo = 0;
    int          lowEdge = 0;
    int          checkedCount = 0;
    int          cycleCount = 0;

    tbClock #(.RESET_CYCLES(RESET_CYCLES)) i_tbClock (
        .CLK40  (CLK40),
        .RESETn (RESETn)
    );

    u712Bus i_u712Bus (
        .CLK40   (CLK40),
        .RESETn  (RESETn),
        .TSn     (TSn),
        .address (address),
        .RWn     (RWn),
        .SIZ     (SIZ),
        .dataIn  (dataIn),
        .TACKn   (TACKn),
        .TBIn    (TBIn),
        .TCIn    (TCIn),
        .tackOe  (tackOe),
        .dataOut (dataOut),
        .dataOe  (dataOe)
    );

    ////////////////////
    // failure reporting
    ////////////////////

    task automatic stopOnFailure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        stopOnFailure();
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        stopOnFailure();
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else reportMismatch(name, 32'(expected), 32'(actual));
    endtask

    ////////////////////
    // random numbers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] drawBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // big-endian lanes, offset 0 is the top byte of the longword
    function automatic logic [31:0] laneMask(input xferSize size, input logic [1:0] offs);
        logic [31:0] mask;
        case (size)
            byteSize: mask = 32'hFF00_0000 >> (8 * offs);
            wordSize: mask = offs[1] ? 32'h0000_FFFF : 32'hFFFF_0000;
            default:  mask = 32'hFFFF_FFFF;
        endcase
        return mask;
    endfunction

    // applies one cycle to the model and returns the data a read must see
    function automatic logic [31:0] refAccess(input logic isReg, input logic [31:0] addr,
                                              input logic rd, input xferSize size,
                                              input logic [31:0] data);
        logic [31:0] result;
        logic [31:0] mask;
        logic [7:0]  word;
        result = '0;
        if (isReg) begin
            case (addr[3:2])
                regId:          result = `U712_ID;
                regScratch:     result = refScratch;
                regAccessCount: result = 32'(refCount);
                default:        result = '0;
            endcase
            if (!rd && addr[3:2] == regScratch) begin
                refScratch = data;
            end
            // counter reads show the accesses before this one
            refCount = refCount + 1;
        end else begin
            word = addr[9:2];
            mask = laneMask(size, addr[1:0]);
            result = refRam[word];
            if (!rd) begin
                refRam[word] = (refRam[word] & ~mask) | (data & mask);
            end
        end
        return result;
    endfunction

    // initial RAM contents, scrambled from the full address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // called on a rising edge, returns on the edge where tackOe is seen low
    task automatic issueCycle(input logic isReg, input logic [31:0] addr, input logic rd,
                              input xferSize size, input logic [31:0] data);
        expItem item;
        item.isReg = isReg;
        item.rd    = rd;
        item.data  = refAccess(isReg, addr, rd, size, data);
        expQ.push_back(item);
        TSn     <= 1'b0;
        address <= addr;
        RWn     <= rd;
        SIZ     <= size;
        dataIn  <= data;
        @(posedge CLK40);
        // single clock start strobe
        TSn <= 1'b1;
        while (tackOe !== 1'b1) @(posedge CLK40);
        while (tackOe !== 1'b0) @(posedge CLK40);
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  idx;
        logic [1:0]  offs;
        logic [1:0]  pick;
        logic        rd;
        xferSize     size;
        TSn        <= 1'b1;
        address    <= '0;
        RWn        <= 1'b1;
        SIZ        <= longSize;
        dataIn     <= '0;
        lfsrState  = LFSR_SEED;
        refScratch = '0;
        refCount   = 0;
        for (int w = 0; w < `CHIP_WORDS; w++) begin
            refRam[w] = '0;
        end
        wait (RESETn === 1'b1);
        // a few idle clocks so the reset state gets checked
        repeat (3) @(posedge CLK40);

        // words in use are {idx, idx}, spread over the array
        for (int w = 0; w < FILL_WORDS; w++) begin
            idx  = 4'(w);
            addr = `CHIP_BASE + 32'({idx, idx, 2'b00});
            issueCycle(1'b0, addr, 1'b0, longSize, fillWord(addr));
        end

        for (int n = FILL_WORDS; n < NUM_CYCLES; n++) begin
            pick = 2'(drawBits(2));
            rd   = 1'(drawBits(1));
            data = drawBits(32);
            if (pick == 2'd0) begin
                // register slots are longword only, slot 3 is unused
                offs = 2'(drawBits(2));
                addr = `REG_BASE + 32'({offs, 2'b00});
                issueCycle(1'b1, addr, rd, longSize, data);
            end else begin
                idx = 4'(drawBits(4));
                if (rd) begin
                    size = longSize;
                    offs = 2'b00;
                end else begin
                    case (2'(drawBits(2)))
                        2'd0:    size = byteSize;
                        2'd1:    size = wordSize;
                        default: size = longSize;
                    endcase
                    offs = 2'(drawBits(2));
                    if (size == wordSize) begin
                        offs[0] = 1'b0;
                    end else if (size == longSize) begin
                        offs = 2'b00;
                    end
                end
                addr = `CHIP_BASE + 32'({idx, idx, offs});
                issueCycle(1'b0, addr, rd, size, data);
            end
        end

        // let the checker close the last cycle
        repeat (2) @(posedge CLK40);
        if (expQ.size() == 0 && !active && checkedCount == NUM_CYCLES) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abortRun("not every issued cycle was terminated and checked");
        end
    end

    ////////////////////
    // checking
    ////////////////////

    // values seen on edge n were set by edge n-1, edge 0 samples TSn low
    always @(posedge CLK40) begin
        if (RESETn) begin
            if (active) begin
                edgeNo = edgeNo + 1;
                // low for one clock, high with tackOe for one, then released
                checkBit("TACKn", edgeNo != lowEdge, TACKn);
                checkBit("TBIn", edgeNo != lowEdge, TBIn);
                checkBit("TCIn", edgeNo != lowEdge, TCIn);
                checkBit("tackOe", edgeNo == lowEdge || edgeNo == lowEdge + 1, tackOe);
                checkBit("dataOe", cur.rd && edgeNo == lowEdge, dataOe);
                if (cur.rd && edgeNo == lowEdge) begin
                    assert (dataOut === cur.data)
                        else reportMismatch("dataOut", cur.data, dataOut);
                end
                if (edgeNo == lowEdge + 2) begin
                    active = 1'b0;
                    checkedCount = checkedCount + 1;
                end
            end else begin
                // bus idle, also the state right after reset
                checkBit("TACKn", 1'b1, TACKn);
                checkBit("TBIn", 1'b1, TBIn);
                checkBit("TCIn", 1'b1, TCIn);
                checkBit("tackOe", 1'b0, tackOe);
                checkBit("dataOe", 1'b0, dataOe);
            end
            if (!TSn) begin
                assert (!active) else abortRun("TSn was issued while a cycle was still open");
                assert (expQ.size() > 0) else abortRun("TSn was seen with no cycle queued");
                cur = expQ.pop_front();
                // TACKn low after edge 4, or 4 plus the chip RAM wait states
                lowEdge = cur.isReg ? 5 : 5 + `CHIP_WAIT;
                edgeNo = 0;
                active = 1'b1;
            end
        end
    end

    // run limit from the number of cycles issued
    always @(posedge CLK40) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            abortRun("the bus never terminated all cycles within the cycle limit");
        end
    end

endmodule

// File: verilog.f
+incdir+.
busPkg.sv
regPkg.sv
cpuCycleIf.sv
cycleDecode.sv
regBlock.sv
chipRamCtrl.sv
cycleTerm.sv
u712Bus.sv
tbClock.sv
tbU712Bus.sv

// File: Makefile
# Verilator build and run of the U712 bus testbench

TOP := tbU712Bus

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): verilog.f *.sv u712_defs.svh
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
